// File: vtx_core.f
logic/vtx_core_pkg.sv
logic/vtx_core_ctrl.sv
logic/vtx_perf_timer.sv
logic/vtx_fetch_stage.sv
logic/vtx_decode_stage.sv
logic/vtx_regfile.sv
logic/vtx_execute_stage.sv
logic/vtx_core.sv
sim/vtx_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= vtx_core_tb
RTL_TOP   ?= vtx_core
FILELIST  ?= vtx_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/vtx_core_vectors.txt
// Header: mode words pairs instr_count final_state error_code stall_count
// Mode 0 ready always, 1 random ready gaps, 2 ready never. Stall count FFFFFFFF is unchecked
// Then the program words, then the expected (rd data) retire pairs. Mode FFFFFFFF ends the file

// Independent ALU and ADDI ops, the r0 write must not show up in r9
00000000 0000000B 0000000A 0000000A 00000003 00000000 00000000
61000005 6200FFFD 60000077 63001234
14120000 25310000 36230000 47130000
58210000 69000001 F0000000
1 00000005  2 FFFFFFFD  0 00000077  3 00001234
4 00000002  5 0000122F  6 00001234  7 00001235
8 FFFFFFF8  9 00000001

// Back-to-back dependent chain, one stall per link
00000000 00000009 00000008 00000008 00000003 00000000 00000007
61000010 62100003 13210000 24320000
55410000 46530000 37660000 6770FFFF
F0000000
1 00000010  2 00000013  3 00000023  4 00000010
5 00000000  6 00000023  7 00000023  7 00000022

// Same chain under random fetch back-pressure
00000001 00000009 00000008 00000008 00000003 00000000 FFFFFFFF
61000010 62100003 13210000 24320000
55410000 46530000 37660000 6770FFFF
F0000000
1 00000010  2 00000013  3 00000023  4 00000010
5 00000000  6 00000023  7 00000023  7 00000022

// Memory never answers
00000002 00000002 00000000 00000000 00000003 00000001 00000000
61000001 F0000000

// Opcode 7 is illegal, the ADDI behind it never retires
00000000 00000005 00000002 00000002 00000003 00000002 00000000
61000007 62000009 70000000 63000001
F0000000
1 00000007  2 00000009

FFFFFFFF

// File: sim/vtx_core_tb.sv
`timescale 1ns/1ps

module vtx_core_tb
    import vtx_core_pkg::*;
();

    // ==================================================
    // Constants and DUT signals
    // ==================================================
    localparam string VEC_FILE      = "sim/vtx_core_vectors.txt";
    localparam int    VEC_DEPTH     = 512;
    localparam int    PROG_DEPTH    = 64;             // Words in the memory model
    localparam int    HDR_WORDS     = 7;              // Scenario header length
    localparam int    SEED          = 25690;
    localparam int    SETTLE_CYCLES = 6;              // Cycles watched in the final state
    localparam word_t END_MARK      = 32'hFFFF_FFFF;
    localparam word_t STALL_ANY     = 32'hFFFF_FFFF;  // Stall count left unchecked
    localparam word_t MODE_ALWAYS   = 32'd0;
    localparam word_t MODE_RANDOM   = 32'd1;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               imem_req;
    word_t              imem_addr;
    word_t              imem_data;
    logic               imem_ready;
    logic               retire_valid;
    reg_idx_t           retire_rd;
    word_t              retire_data;
    core_state_t        core_state;
    logic               error_valid;
    err_code_t          error_code;
    logic [COUNT_W-1:0] cycle_count;
    logic [COUNT_W-1:0] instr_count;
    logic [COUNT_W-1:0] stall_count;

    word_t vec_mem  [VEC_DEPTH];
    word_t prog_mem [PROG_DEPTH];
    int    prog_len  = 0;
    int    wd_cycles = 0;                              // Zero until the file is parsed
    int    scen_num  = 0;

    vtx_core vtx_core_i (
        .clk, .rst_n, .start, .imem_req, .imem_addr, .imem_data, .imem_ready,
        .retire_valid, .retire_rd, .retire_data, .core_state, .error_valid,
        .error_code, .cycle_count, .instr_count, .stall_count
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                             // 100 ns period

    // Instruction memory, word address picks the entry, NOP past the end
    assign imem_data = (int'(imem_addr[31:2]) < prog_len) ? prog_mem[imem_addr[7:2]] : '0;

    // ==================================================
    // Error reporting and compare tasks
    // ==================================================
    task automatic report_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected r%0d, actual r%0d", name, exp, act));
    endtask

    task automatic check_state(input string name, input core_state_t exp,
                               input core_state_t act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_err(input string name, input err_code_t exp, input err_code_t act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
                               input logic [COUNT_W-1:0] act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_error($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    function automatic logic ready_for(input word_t mode);
        case (mode)
            MODE_ALWAYS: return 1'b1;
            MODE_RANDOM: return ($urandom % 3) != 0;   // Roughly one gap in three
            default:     return 1'b0;                  // Memory never answers
        endcase
    endfunction

    task automatic apply_reset();
        rst_n      = 1'b0;
        start      = 1'b0;
        imem_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_scenario(input int base, output int next);
        word_t     mode;
        int        n_prog;
        int        n_pairs;
        int        pair_base;
        int        got;
        int        settle;
        int        cyc;
        int        fetched;
        int        exp_cycles;
        logic      stop_seen;
        word_t     fetch_word;
        string     tag;
        err_code_t exp_err;

        mode      = vec_mem[base];
        n_prog    = int'(vec_mem[base + 1]);
        n_pairs   = int'(vec_mem[base + 2]);
        exp_err   = err_code_t'(vec_mem[base + 5][1:0]);
        pair_base = base + HDR_WORDS + n_prog;
        next      = pair_base + 2 * n_pairs;
        for (int i = 0; i < n_prog; i++) begin
            prog_mem[i] = vec_mem[base + HDR_WORDS + i];
        end
        prog_len = n_prog;
        scen_num++;
        tag = $sformatf("scenario %0d", scen_num);

        apply_reset();
        @(negedge clk);
        check_flag({tag, " imem_req after reset"}, 1'b0, imem_req);
        check_flag({tag, " retire_valid after reset"}, 1'b0, retire_valid);
        check_flag({tag, " error_valid after reset"}, 1'b0, error_valid);
        check_state({tag, " state after reset"}, ST_IDLE, core_state);

        got        = 0;
        settle     = 0;
        cyc        = 0;
        fetched    = 0;
        exp_cycles = FETCH_TIMEOUT_CYCLES;             // Memory never answers
        stop_seen  = 1'b0;
        while (settle < SETTLE_CYCLES) begin
            @(posedge clk);
            #1;
            start      = (cyc == 0);                   // One-cycle start pulse
            imem_ready = ready_for(mode);
            cyc++;
            @(negedge clk);                            // Outputs settled mid-cycle
            if (imem_req && imem_ready) begin
                check_word($sformatf("%s fetch %0d address", tag, fetched),
                           word_t'(4 * fetched), imem_addr);
                fetch_word = (fetched < prog_len) ? prog_mem[fetched] : '0;
                // RUN starts at cyc 1, the first stopping word sets the end
                if (!stop_seen && fetch_word[31:28] == 4'hF) begin
                    exp_cycles = cyc + 2;              // Decode, drain, retire
                    stop_seen  = 1'b1;
                end else if (!stop_seen && fetch_word[31:28] > 4'h6) begin
                    exp_cycles = cyc;                  // Fault right after decode
                    stop_seen  = 1'b1;
                end
                fetched++;
            end
            if (retire_valid) begin
                if (got >= n_pairs)
                    report_error($sformatf("%s retired more instructions than expected", tag));
                check_idx($sformatf("%s retire %0d rd", tag, got),
                          vec_mem[pair_base + 2 * got][3:0], retire_rd);
                check_word($sformatf("%s retire %0d data", tag, got),
                           vec_mem[pair_base + 2 * got + 1], retire_data);
                got++;
            end
            if (core_state == ST_HALTED_OR_FAULT) begin
                check_flag({tag, " imem_req in final state"}, 1'b0, imem_req);
                settle++;
            end
        end

        check_count({tag, " retire pulses"}, COUNT_W'(n_pairs), COUNT_W'(got));
        check_count({tag, " instr_count"}, vec_mem[base + 3], instr_count);
        check_count({tag, " cycle_count"}, COUNT_W'(exp_cycles), cycle_count);
        check_state({tag, " final state"}, core_state_t'(vec_mem[base + 4][1:0]), core_state);
        check_flag({tag, " error_valid"}, exp_err != ERR_NONE, error_valid);
        check_err({tag, " error_code"}, exp_err, error_code);
        if (vec_mem[base + 6] != STALL_ANY)
            check_count({tag, " stall_count"}, vec_mem[base + 6], stall_count);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        int pos;
        int total_words;

        rst_n      = 1'b0;
        start      = 1'b0;
        imem_ready = 1'b0;
        void'($urandom(SEED));
        $readmemh(VEC_FILE, vec_mem);

        // Walk the headers once, program words set the time budget
        pos         = 0;
        total_words = 0;
        while (vec_mem[pos] !== END_MARK) begin
            if (pos >= VEC_DEPTH - HDR_WORDS || int'(vec_mem[pos + 1]) > PROG_DEPTH)
                report_error("Vector file is malformed or has no end marker");
            total_words += int'(vec_mem[pos + 1]);
            pos += HDR_WORDS + int'(vec_mem[pos + 1]) + 2 * int'(vec_mem[pos + 2]);
        end
        wd_cycles = 40 * total_words + 200;

        pos = 0;
        while (vec_mem[pos] !== END_MARK) begin
            run_scenario(pos, pos);
        end

        $display("Verification passed");
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        report_error($sformatf("Timeout, the run did not finish within %0d cycles", wd_cycles));
    end

endmodule

// File: logic/vtx_core.sv
`timescale 1ns/1ps

module vtx_core
    import vtx_core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               imem_req,
    output word_t              imem_addr,
    input  word_t              imem_data,
    input  logic               imem_ready,
    output logic               retire_valid,
    output reg_idx_t           retire_rd,
    output word_t              retire_data,
    output core_state_t        core_state,
    output logic               error_valid,
    output err_code_t          error_code,
    output logic [COUNT_W-1:0] cycle_count,
    output logic [COUNT_W-1:0] instr_count,
    output logic [COUNT_W-1:0] stall_count
);

    // Control
    logic     fetch_en;
    logic     decode_kill;
    logic     hazard_stall;
    logic     halt_seen;
    logic     illegal_seen;
    logic     halt_retired;
    logic     fetch_timeout;
    // Fetch to decode
    logic     fetch_valid;
    word_t    fetch_instr;
    // Register file reads
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    // Decode to execute
    logic     exe_valid;
    opcode_t  exe_op;
    reg_idx_t exe_rd;
    word_t    exe_a;
    word_t    exe_b;

    vtx_core_ctrl ctrl_i (
        .clk, .rst_n, .start, .halt_seen, .illegal_seen, .halt_retired,
        .fetch_timeout, .fetch_en, .decode_kill, .core_state, .error_valid, .error_code
    );

    vtx_perf_timer timer_i (
        .clk, .rst_n, .core_state, .imem_req, .imem_ready, .hazard_stall,
        .retire_valid, .fetch_timeout, .cycle_count, .instr_count, .stall_count
    );

    vtx_fetch_stage fetch_i (
        .clk, .rst_n, .fetch_en, .hazard_stall, .imem_req, .imem_addr,
        .imem_data, .imem_ready, .fetch_valid, .fetch_instr
    );

    vtx_decode_stage decode_i (
        .clk, .rst_n, .fetch_valid, .fetch_instr, .decode_kill, .rs1_idx, .rs2_idx,
        .rs1_data, .rs2_data, .exe_valid, .exe_op, .exe_rd, .exe_a, .exe_b,
        .hazard_stall, .halt_seen, .illegal_seen
    );

    // Write port fed straight from the retire register
    vtx_regfile regfile_i (
        .clk, .rst_n, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wr_en(retire_valid), .wr_idx(retire_rd), .wr_data(retire_data)
    );

    vtx_execute_stage execute_i (
        .clk, .rst_n, .exe_valid, .exe_op, .exe_rd, .exe_a, .exe_b,
        .retire_valid, .retire_rd, .retire_data, .halt_retired
    );

endmodule

// File: logic/vtx_execute_stage.sv
`timescale 1ns/1ps

module vtx_execute_stage
    import vtx_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exe_valid,
    input  opcode_t  exe_op,
    input  reg_idx_t exe_rd,
    input  word_t    exe_a,
    input  word_t    exe_b,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output word_t    retire_data,
    output logic     halt_retired
);

    word_t alu_res;
    logic  has_result;                      // Op produces a register write

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        has_result = 1'b1;
        case (exe_op)
            OP_ADD:  alu_res = exe_a + exe_b;
            OP_ADDI: alu_res = exe_a + exe_b;   // exe_b holds the immediate
            OP_SUB:  alu_res = exe_a - exe_b;
            OP_AND:  alu_res = exe_a & exe_b;
            OP_OR:   alu_res = exe_a | exe_b;
            OP_XOR:  alu_res = exe_a ^ exe_b;
            default: begin
                alu_res    = '0;            // NOP and HALT
                has_result = 1'b0;
            end
        endcase
    end

    // ==================================================
    // Writeback register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halt_retired <= 1'b0;
        end else begin
            retire_valid <= exe_valid && has_result;
            halt_retired <= exe_valid && (exe_op == OP_HALT);   // Ends the drain
        end
    end

    // Also the regfile write port
    always_ff @(posedge clk) begin
        if (exe_valid && has_result) begin
            retire_rd   <= exe_rd;
            retire_data <= alu_res;
        end
    end

endmodule

// File: logic/vtx_regfile.sv
`timescale 1ns/1ps

module vtx_regfile
    import vtx_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [NUM_REGS];

    // r0 forced to zero, same-cycle write seen by the reads
    assign rs1_data = (rs1_idx == '0)                ? '0      :
                      (wr_en && (wr_idx == rs1_idx)) ? wr_data : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0)                ? '0      :
                      (wr_en && (wr_idx == rs2_idx)) ? wr_data : regs[rs2_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;        // Writes to r0 dropped
        end
    end

endmodule

// File: logic/vtx_decode_stage.sv
`timescale 1ns/1ps

module vtx_decode_stage
    import vtx_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  word_t    fetch_instr,
    input  logic     decode_kill,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     exe_valid,
    output opcode_t  exe_op,
    output reg_idx_t exe_rd,
    output word_t    exe_a,
    output word_t    exe_b,
    output logic     hazard_stall,
    output logic     halt_seen,
    output logic     illegal_seen
);

    opcode_t  op;
    reg_idx_t rd;
    word_t    imm_ext;
    logic     live;                         // Valid and not flushed
    logic     is_legal;
    logic     is_addi;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     writes_rd;
    logic     rs1_hit;
    logic     rs2_hit;

    // ==================================================
    // Field extraction
    // ==================================================
    assign op      = opcode_t'(fetch_instr[OPC_MSB:OPC_LSB]);
    assign rd      = fetch_instr[RD_MSB:RD_LSB];
    assign rs1_idx = fetch_instr[RS1_MSB:RS1_LSB];   // Straight to regfile
    assign rs2_idx = fetch_instr[RS2_MSB:RS2_LSB];
    assign imm_ext = {{(WORD_W - IMM_MSB - 1){fetch_instr[IMM_MSB]}},
                      fetch_instr[IMM_MSB:IMM_LSB]};

    always_comb begin
        is_legal = 1'b1;
        is_addi  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_ADDI: begin
                is_addi  = 1'b1;
                uses_rs1 = 1'b1;
            end
            OP_NOP, OP_HALT: ;              // No sources, no result
            default: is_legal = 1'b0;
        endcase
    end

    assign writes_rd = uses_rs1;            // Every op with a source writes rd
    assign live      = fetch_valid && !decode_kill;

    // RAW against execute only, writeback is bypassed in the regfile
    assign rs1_hit      = uses_rs1 && (rs1_idx == exe_rd);
    assign rs2_hit      = uses_rs2 && (rs2_idx == exe_rd);
    assign hazard_stall = live && exe_valid && (exe_rd != '0) && (rs1_hit || rs2_hit);

    assign halt_seen    = live && (op == OP_HALT);
    assign illegal_seen = live && !is_legal;

    // ==================================================
    // Decode to execute register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= live && is_legal && !hazard_stall;  // Stall inserts a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (live && !hazard_stall) begin
            exe_op <= op;
            exe_rd <= writes_rd ? rd : '0;  // r0 marks no destination
            exe_a  <= rs1_data;
            exe_b  <= is_addi ? imm_ext : rs2_data;
        end
    end

    // Fetch holds the stalled word, and the stall lasts one cycle
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_stall |=> fetch_valid && $stable(fetch_instr) && !hazard_stall);

endmodule

// File: logic/vtx_fetch_stage.sv
`timescale 1ns/1ps

module vtx_fetch_stage
    import vtx_core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_en,
    input  logic  hazard_stall,
    output logic  imem_req,
    output word_t imem_addr,
    input  word_t imem_data,
    input  logic  imem_ready,
    output logic  fetch_valid,
    output word_t fetch_instr
);

    word_t pc;
    logic  accept;                          // Handshake completes this cycle

    // No new request while decode holds the fetch register
    // A stall only starts right after an accept, so a pending request never drops
    assign imem_req  = fetch_en && !hazard_stall;
    assign imem_addr = pc;
    assign accept    = imem_req && imem_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            if (accept) begin
                pc <= pc + PC_STEP;         // Next sequential word
            end
            if (!hazard_stall) begin
                fetch_valid <= accept;      // Bubble when memory is slow
            end
        end
    end

    // Instruction payload
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_instr <= imem_data;
        end
    end

endmodule

// File: logic/vtx_perf_timer.sv
`timescale 1ns/1ps

module vtx_perf_timer
    import vtx_core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  core_state_t        core_state,
    input  logic               imem_req,
    input  logic               imem_ready,
    input  logic               hazard_stall,
    input  logic               retire_valid,
    output logic               fetch_timeout,
    output logic [COUNT_W-1:0] cycle_count,
    output logic [COUNT_W-1:0] instr_count,
    output logic [COUNT_W-1:0] stall_count
);

    localparam int WAIT_W = $clog2(FETCH_TIMEOUT_CYCLES + 1);

    logic [WAIT_W-1:0] wait_cnt;            // Consecutive unanswered cycles
    logic              fetch_waiting;
    logic              core_active;

    assign fetch_waiting = imem_req && !imem_ready;
    assign core_active   = (core_state == ST_RUN) || (core_state == ST_DRAIN);

    // Fires on the last allowed waiting cycle
    assign fetch_timeout = fetch_waiting &&
                           (wait_cnt == WAIT_W'(FETCH_TIMEOUT_CYCLES - 1));

    // ==================================================
    // Fetch watchdog
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!fetch_waiting || fetch_timeout) begin
            wait_cnt <= '0;                 // Answered, dropped or expired
        end else begin
            wait_cnt <= wait_cnt + WAIT_W'(1);
        end
    end

    // ==================================================
    // Performance counters
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
            instr_count <= '0;
            stall_count <= '0;
        end else begin
            if (core_active) cycle_count <= cycle_count + COUNT_W'(1);
            if (retire_valid) instr_count <= instr_count + COUNT_W'(1);
            if (hazard_stall) stall_count <= stall_count + COUNT_W'(1);
        end
    end

endmodule

// File: logic/vtx_core_ctrl.sv
`timescale 1ns/1ps

module vtx_core_ctrl
    import vtx_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        halt_seen,
    input  logic        illegal_seen,
    input  logic        halt_retired,
    input  logic        fetch_timeout,
    output logic        fetch_en,
    output logic        decode_kill,
    output core_state_t core_state,
    output logic        error_valid,
    output err_code_t   error_code
);

    core_state_t state_q;
    core_state_t state_d;
    err_code_t   err_d;
    logic        take_fault;

    // Errors only count while the pipe is live
    assign take_fault = (fetch_timeout || illegal_seen) &&
                        (state_q == ST_RUN || state_q == ST_DRAIN);

    always_comb begin
        state_d = state_q;
        err_d   = ERR_NONE;
        if (fetch_timeout) begin
            err_d = ERR_FETCH_TIMEOUT;      // Timeout wins a tie
        end else if (illegal_seen) begin
            err_d = ERR_ILLEGAL_OP;
        end
        case (state_q)
            ST_IDLE:  if (start) state_d = ST_RUN;
            ST_RUN: begin
                if (take_fault) state_d = ST_HALTED_OR_FAULT;
                else if (halt_seen) state_d = ST_DRAIN;     // Stop fetching
            end
            ST_DRAIN: begin
                if (take_fault || halt_retired) state_d = ST_HALTED_OR_FAULT;
            end
            default:  state_d = state_q;    // Terminal until reset
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            error_valid <= 1'b0;
            error_code  <= ERR_NONE;
        end else begin
            state_q <= state_d;
            if (take_fault && !error_valid) begin
                error_valid <= 1'b1;
                error_code  <= err_d;       // First error sticks
            end
        end
    end

    assign core_state  = state_q;
    assign fetch_en    = (state_q == ST_RUN);
    assign decode_kill = (state_q != ST_RUN);  // Flush decode outside RUN

    // ==================================================
    // Checks
    // ==================================================
    // Fetch stops the cycle after HALT or a fault
    a_fetch_stops: assert property (@(posedge clk) disable iff (!rst_n)
        (halt_seen || take_fault) |=> !fetch_en);

    // A reported error sits in the final state with a real code
    a_error_in_final: assert property (@(posedge clk) disable iff (!rst_n)
        error_valid |-> (core_state == ST_HALTED_OR_FAULT) && (error_code != ERR_NONE));

endmodule

// File: logic/vtx_core_pkg.sv
package vtx_core_pkg;

    // ==================================================
    // Widths and basic types
    // ==================================================
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;            // r0 reads as zero
    localparam int COUNT_W   = 32;            // Perf counter width

    typedef logic [WORD_W-1:0]    word_t;     // Data, PC or instruction
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Instruction field positions
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int RD_MSB  = 27;
    localparam int RD_LSB  = 24;
    localparam int RS1_MSB = 23;
    localparam int RS1_LSB = 20;
    localparam int RS2_MSB = 19;
    localparam int RS2_LSB = 16;
    localparam int IMM_MSB = 15;              // Also the immediate sign bit
    localparam int IMM_LSB = 0;

    localparam word_t PC_STEP = 32'd4;        // Byte step per fetch

    // ==================================================
    // Encodings
    // ==================================================
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,                       // rs1 + sext(imm16)
        OP_HALT = 4'hF                        // Codes 7 to E are illegal
    } opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE            = 2'd0,
        ST_RUN             = 2'd1,
        ST_DRAIN           = 2'd2,            // HALT seen, pipe emptying
        ST_HALTED_OR_FAULT = 2'd3             // error_valid tells which
    } core_state_t;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_FETCH_TIMEOUT = 2'd1,
        ERR_ILLEGAL_OP    = 2'd2
    } err_code_t;

    // Timing
    localparam int FETCH_TIMEOUT_CYCLES = 16; // Unanswered fetch limit

endpackage
